/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;
	localparam int queue_depth = 4;
	localparam int mem_words = 256;
	localparam int qptr_w = $clog2(queue_depth);
	localparam int qcnt_w = $clog2(queue_depth + 1);
	localparam int mem_aw = $clog2(mem_words);

	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_op_imm = 7'b0010011;
	localparam logic [6:0] op_op = 7'b0110011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;

	localparam logic [2:0] f3_byte = 3'b000;
	localparam logic [2:0] f3_half = 3'b001;
	localparam logic [2:0] f3_word = 3'b010;
	localparam logic [2:0] f3_add = 3'b000;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} u_fmt_t;

	typedef struct packed {
		logic imm_20;
		logic [9:0] imm_10_1;
		logic imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	typedef struct packed {
		logic [xlen-1:0] pc;
		instr_u instr;
	} trace_rec_t;

	typedef enum logic [3:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_addi,
		cls_add,
		cls_load,
		cls_store,
		cls_none
	} op_class_e;

	typedef struct packed {
		op_class_e cls;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [4:0] rd;
		logic [xlen-1:0] imm;
		logic [2:0] funct3;
		logic [xlen-1:0] pc;
	} dec_t;

	typedef struct packed {
		logic [4:0] rd;
		logic wen;
		logic [xlen-1:0] wdata;
		logic [xlen-1:0] next_pc;
	} retire_t;

endpackage

`default_nettype wire

/* src/instr_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_queue import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input trace_rec_t in_rec,
	input logic deq,
	output logic head_valid,
	output trace_rec_t head,
	output logic credit_return
);

	trace_rec_t entries [queue_depth];
	logic [qptr_w-1:0] wr_ptr;
	logic [qptr_w-1:0] rd_ptr;
	logic [qcnt_w-1:0] count;
	logic pop;

	assign head_valid = count != '0;
	assign head = entries[rd_ptr];
	assign pop = deq & head_valid; // never pop an empty queue

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_return <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == qptr_w'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == qptr_w'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + qcnt_w'(in_valid) - qcnt_w'(pop);
			credit_return <= pop; // one credit back per entry served
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			entries[wr_ptr] <= in_rec;
	end

endmodule

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import rv_pkg::*; (
	input trace_rec_t rec,
	output dec_t dec
);

	instr_u ins;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	op_class_e cls;

	assign ins = rec.instr;
	assign opcode = ins.r_fmt.opcode;
	assign funct3 = ins.r_fmt.funct3;
	assign funct7 = ins.r_fmt.funct7;

	// opcode first, then funct3, then funct7
	always_comb begin
		cls = cls_none;
		case (opcode)
			op_lui: cls = cls_lui;
			op_auipc: cls = cls_auipc;
			op_jal: cls = cls_jal;
			op_jalr: if (funct3 == 3'b000) cls = cls_jalr;
			op_op_imm: if (funct3 == f3_add) cls = cls_addi;
			op_load: if (funct3 == f3_word) cls = cls_load;
			op_store: begin
				if (funct3 == f3_byte || funct3 == f3_half || funct3 == f3_word)
					cls = cls_store;
			end
			op_op: if (funct3 == f3_add && funct7 == 7'b0000000) cls = cls_add;
			default: cls = cls_none;
		endcase
	end

	always_comb begin
		dec.cls = cls;
		dec.rs1 = ins.r_fmt.rs1;
		dec.rs2 = ins.r_fmt.rs2;
		dec.funct3 = funct3;
		dec.pc = rec.pc;
		dec.rd = (cls == cls_store || cls == cls_none) ? 5'd0 : ins.r_fmt.rd;
		case (opcode)
			op_lui, op_auipc: dec.imm = {ins.u_fmt.imm_31_12, 12'b0};
			op_jal: dec.imm = {{12{ins.j_fmt.imm_20}}, ins.j_fmt.imm_19_12,
				ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
			op_store: dec.imm = {{20{ins.s_fmt.imm_11_5[6]}}, ins.s_fmt.imm_11_5,
				ins.s_fmt.imm_4_0};
			default: dec.imm = {{20{ins.i_fmt.imm_11_0[11]}}, ins.i_fmt.imm_11_0};
		endcase
	end

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [4:0] rs1,
	input logic [4:0] rs2,
	input logic [4:0] rd,
	input logic wen,
	input logic [xlen-1:0] wdata,
	output logic [xlen-1:0] src1,
	output logic [xlen-1:0] src2
);

	logic [xlen-1:0] regs [32];

	assign src1 = regs[rs1];
	assign src2 = regs[rs2];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wen && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= wdata;
		end
	end

endmodule

`default_nettype wire

/* src/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import rv_pkg::*; (
	input dec_t dec,
	input logic [xlen-1:0] src1,
	input logic [xlen-1:0] src2,
	input logic [xlen-1:0] rdata,
	output logic [xlen-1:0] result,
	output logic [xlen-1:0] jump_target,
	output logic [xlen-1:0] mem_addr,
	output logic [xlen-1:0] wdata_lane,
	output logic taken,
	output logic wen_rd,
	output logic mem_we,
	output logic [3:0] mem_mask
);

	logic [xlen-1:0] pc_plus4;
	logic [3:0] lane_mask;

	assign pc_plus4 = dec.pc + xlen'(4);
	assign mem_addr = src1 + dec.imm; // shared by loads and stores

	always_comb begin
		result = '0;
		jump_target = '0;
		taken = 1'b0;
		case (dec.cls)
			cls_lui: result = dec.imm;
			cls_auipc: result = dec.pc + dec.imm;
			cls_jal: begin
				result = pc_plus4;
				jump_target = dec.pc + dec.imm;
				taken = 1'b1;
			end
			cls_jalr: begin
				result = pc_plus4;
				jump_target = (src1 + dec.imm) & ~xlen'(1);
				taken = 1'b1;
			end
			cls_addi: result = src1 + dec.imm;
			cls_add: result = src1 + src2;
			cls_load: result = rdata;
			default: result = '0;
		endcase
	end

	// lanes before the address shift
	always_comb begin
		case (dec.funct3)
			f3_byte: lane_mask = 4'b0001;
			f3_half: lane_mask = 4'b0011;
			f3_word: lane_mask = 4'b1111;
			default: lane_mask = 4'b0000;
		endcase
	end

	assign mem_we = dec.cls == cls_store;
	assign mem_mask = mem_we ? lane_mask << mem_addr[1:0] : 4'b0000;
	assign wdata_lane = src2 << {mem_addr[1:0], 3'b000}; // align data to mask

	assign wen_rd = (dec.cls != cls_store) && (dec.cls != cls_none);

endmodule

`default_nettype wire

/* src/data_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_mem import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [xlen-1:0] addr,
	input logic we,
	input logic [3:0] mask,
	input logic [xlen-1:0] wdata,
	output logic [xlen-1:0] rdata
);

	logic [xlen-1:0] mem [mem_words];
	logic [mem_aw-1:0] idx;

	assign idx = addr[mem_aw+1:2]; // word index
	assign rdata = mem[idx];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int w = 0; w < mem_words; w++)
				mem[w] <= '0;
		end else if (we) begin
			for (int b = 0; b < 4; b++) begin
				if (mask[b])
					mem[idx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input trace_rec_t in_rec,
	output logic credit_return,
	output logic ret_valid,
	output retire_t ret
);

	logic head_valid;
	trace_rec_t head;
	logic deq;
	dec_t dec;
	logic [xlen-1:0] src1;
	logic [xlen-1:0] src2;
	logic [xlen-1:0] rdata;
	logic [xlen-1:0] result;
	logic [xlen-1:0] jump_target;
	logic [xlen-1:0] mem_addr;
	logic [xlen-1:0] wdata_lane;
	logic taken;
	logic wen_rd;
	logic mem_we;
	logic [3:0] mem_mask;
	logic [xlen-1:0] next_pc;

	assign deq = head_valid; // one instruction per cycle
	assign next_pc = taken ? jump_target : dec.pc + xlen'(4);

	instr_queue instr_queue_i (.clk, .reset, .in_valid, .in_rec, .deq, .head_valid, .head,
		.credit_return);

	instr_decoder instr_decoder_i (.rec(head), .dec);

	reg_file reg_file_i (.clk, .reset, .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
		.wen(deq & wen_rd), .wdata(result), .src1, .src2);

	exec_unit exec_unit_i (.dec, .src1, .src2, .rdata, .result, .jump_target, .mem_addr,
		.wdata_lane, .taken, .wen_rd, .mem_we, .mem_mask);

	data_mem data_mem_i (.clk, .reset, .addr(mem_addr), .we(deq & mem_we), .mask(mem_mask),
		.wdata(wdata_lane), .rdata);

	always_ff @(posedge clk) begin
		if (reset)
			ret_valid <= 1'b0;
		else
			ret_valid <= deq;
	end

	always_ff @(posedge clk) begin
		if (deq)
			ret <= '{rd: dec.rd, wen: wen_rd, wdata: result, next_pc: next_pc};
	end

endmodule

`default_nettype wire

/* test/rv_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_chk import rv_pkg::*; (
	input logic clk,
	input logic reset,
	input logic deq,
	input logic credit_return,
	input logic ret_valid,
	input logic [qcnt_w-1:0] count
);

	int fail_count = 0;

	count_bound: assert property (@(posedge clk) disable iff (reset) count <= queue_depth)
		else begin
			$error("queue count above depth");
			fail_count++;
		end

	credit_after_deq: assert property (@(posedge clk) disable iff (reset) deq |=> credit_return)
		else begin
			$error("no credit_return after a dequeue");
			fail_count++;
		end

	retire_after_deq: assert property (@(posedge clk) disable iff (reset) deq |=> ret_valid)
		else begin
			$error("no ret_valid after a dequeue");
			fail_count++;
		end

	quiet_after_reset: assert property (@(posedge clk) reset |=> !ret_valid && !credit_return)
		else begin
			$error("outputs active in the cycle after reset");
			fail_count++;
		end

endmodule

bind rv_core rv_core_chk rv_core_chk_i (.clk, .reset, .deq, .credit_return, .ret_valid,
	.count(instr_queue_i.count));

`default_nettype wire

/* test/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

	localparam int total_instr = 370; // sum over all tests

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	trace_rec_t in_rec;
	logic credit_return;
	logic ret_valid;
	retire_t ret;

	logic [31:0] lfsr = 32'd58;
	logic [31:0] regs [8]; // model of x0..x7
	logic [7:0] mem_b [64]; // model of the first 16 words
	retire_t exp_q [$];
	int errors = 0;
	int credits = 0;
	int sent_total = 0;
	int returned = 0;
	int tests = 0;

	rv_core rv_core_i (.clk, .reset, .in_valid, .in_rec, .credit_return, .ret_valid, .ret);

	always #20 clk = ~clk;

	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003; // x^32+x^22+x^2+x+1
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	task automatic compare_field(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	// class indices 0 lui 1 auipc 2 jal 3 jalr 4 addi 5 add 6 lw 7 sb 8 sh 9 sw 10 unknown
	task automatic send_one(input logic [10:0] mask);
		logic [3:0] cls;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [19:0] u;
		logic [11:0] i12;
		logic [31:0] pc;
		logic [31:0] imm;
		logic [31:0] a;
		logic [31:0] word;
		int nb;
		retire_t e;
		cls = rand_bits(4) % 11;
		while (!mask[cls])
			cls = rand_bits(4) % 11;
		rd = rand_bits(3);
		rs1 = rand_bits(3);
		rs2 = rand_bits(3);
		u = rand_bits(20);
		i12 = rand_bits(12);
		pc = rand_bits(16) << 2;
		imm = {{20{i12[11]}}, i12};
		nb = 0;
		e = '{rd: rd, wen: 1'b1, wdata: '0, next_pc: pc + 32'd4};
		case (cls)
			0: begin
				word = {u, rd, op_lui};
				e.wdata = {u, 12'h000};
			end
			1: begin
				word = {u, rd, op_auipc};
				e.wdata = pc + {u, 12'h000};
			end
			2: begin
				word = {u[19], u[9:0], u[10], u[18:11], rd, op_jal}; // u holds imm[20:1]
				e.wdata = pc + 32'd4;
				e.next_pc = pc + {{11{u[19]}}, u, 1'b0};
			end
			3: begin
				word = {i12, rs1, 3'b000, rd, op_jalr};
				e.wdata = pc + 32'd4;
				e.next_pc = (regs[rs1] + imm) & 32'hffff_fffe;
			end
			4: begin
				word = {i12, rs1, f3_add, rd, op_op_imm};
				e.wdata = regs[rs1] + imm;
			end
			5: begin
				word = {7'b0000000, rs2, rs1, f3_add, rd, op_op};
				e.wdata = regs[rs1] + regs[rs2];
			end
			6: begin
				a = rand_bits(4) << 2; // base is x0
				word = {a[11:0], 5'd0, f3_word, rd, op_load};
				e.wdata = {mem_b[a + 3], mem_b[a + 2], mem_b[a + 1], mem_b[a]};
			end
			7, 8, 9: begin
				nb = (cls == 7) ? 1 : (cls == 8) ? 2 : 4;
				a = (cls == 7) ? rand_bits(6) : (cls == 8) ? rand_bits(5) << 1 : rand_bits(4) << 2;
				word = {a[11:5], rs2, 5'd0, (cls == 7) ? f3_byte : (cls == 8) ? f3_half : f3_word,
					a[4:0], op_store};
				e.wen = 1'b0;
			end
			default: begin
				word = {25'(rand_bits(25)), 7'b1110011}; // system opcode is outside the set
				e.wen = 1'b0;
			end
		endcase
		for (int k = 0; k < nb; k++)
			mem_b[a + k] = regs[rs2][8*k +: 8];
		if (e.wen && rd != 5'd0)
			regs[rd] = e.wdata;
		in_rec.pc = pc;
		in_rec.instr = word;
		in_valid = 1'b1;
		credits--;
		sent_total++;
		exp_q.push_back(e);
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		foreach (regs[i])
			regs[i] = '0;
		foreach (mem_b[i])
			mem_b[i] = '0;
		credits = queue_depth;
		repeat (3) @(posedge clk);
		#2;
		reset = 1'b0;
	endtask

	task automatic run_test(input string name, input int n, input logic [10:0] mask);
		int errs0;
		int sent;
		errs0 = errors;
		sent = 0;
		while (sent < n) begin
			@(posedge clk);
			#2;
			in_valid = 1'b0;
			if (credits > 0 && next_bit()) begin // random gaps
				send_one(mask);
				sent++;
			end
		end
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		while (exp_q.size() != 0) begin
			@(posedge clk);
			#2;
		end
		assert (returned == sent_total) else begin
			$display("%0d credits came back for %0d instructions sent", returned, sent_total);
			errors++;
		end
		tests++;
		$display("%s: %0d instructions, %0d errors", name, n, errors - errs0);
	endtask

	// retire and credit monitor
	always @(negedge clk) begin
		retire_t e;
		if (credit_return === 1'b1) begin
			credits++;
			returned++;
			assert (credits <= queue_depth) else begin
				$display("credit returned beyond the queue depth at %0t ns", $time);
				errors++;
			end
		end
		if (ret_valid === 1'b1) begin
			assert (exp_q.size() != 0) else begin
				$display("instruction retired at %0t ns with none outstanding", $time);
				errors++;
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				compare_field("ret.wen", e.wen, ret.wen);
				compare_field("ret.next_pc", e.next_pc, ret.next_pc);
				if (e.wen) begin
					compare_field("ret.rd", e.rd, ret.rd);
					compare_field("ret.wdata", e.wdata, ret.wdata);
				end
			end
		end
	end

	initial begin
		#((total_instr * 4 + 200) * 40);
		$display("timeout: the run did not finish in %0d cycles", total_instr * 4 + 200);
		$display("Test FAILED");
		$finish;
	end

	initial begin
		in_valid = 1'b0;
		in_rec = '0;
		apply_reset();
		run_test("arith", 40, 11'b000_0011_0011);
		run_test("jumps", 30, 11'b000_0001_1101);
		run_test("memory", 40, 11'b011_1101_0000);
		run_test("unknown", 20, 11'b100_0011_0000);
		run_test("credits", 200, 11'b111_1111_1111);
		apply_reset(); // second reset in mid-run
		run_test("reset", 40, 11'b111_1111_1111);
		$display("%0d tests, %0d instructions, %0d errors, %0d assertion failures", tests,
			sent_total, errors, rv_core_i.rv_core_chk_i.fail_count);
		if (errors == 0 && rv_core_i.rv_core_chk_i.fail_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
src/rv_pkg.sv
src/instr_queue.sv
src/instr_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/data_mem.sv
src/rv_core.sv
test/rv_core_chk.sv
test/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/instr_queue.sv
  - src/instr_decoder.sv
  - src/reg_file.sv
  - src/exec_unit.sv
  - src/data_mem.sv
  - src/rv_core.sv
  - target: test
    files:
      - test/rv_core_chk.sv
      - test/rv_core_tb.sv
